// File: rtl/fifo_pkg.sv
package fifo_pkg;

   // operation presented to the single RAM port on a given cycle
   typedef enum logic [1:0]
   {
      op_idle = 2'd0,
      op_enq  = 2'd1,
      op_deq  = 2'd2
   } fifo_op_e;

   // status of the RAM-resident part of the queue only,
   // the dequeue buffer is not counted here
   typedef struct packed
   {
      logic full;
      logic empty;
   } fifo_status_t;

   // default data width in bits
   parameter int default_width = 32;

   // default number of RAM entries
   parameter int default_els = 16;

endpackage

// File: rtl/mem_1rw_sync.sv
`timescale 1ns/10ps

module mem_1rw_sync
#(
   parameter int width_p,
   parameter int els_p
)
(
   input  logic                                  clk_i,
   input  logic                                  v_i,
   input  logic                                  w_i,
   input  logic [((els_p > 1) ? $clog2(els_p) : 1)-1:0] addr_i,
   input  logic [width_p-1:0]                    data_i,
   output logic [width_p-1:0]                    data_o
);

   logic [width_p-1:0] mem_r [els_p];

   // one access per cycle, read data shows up on the next cycle
   // and stays put while the port is idle or writing
   always_ff @(posedge clk_i)
   begin
      if (v_i)
      begin
         if (w_i)
         begin
            mem_r[addr_i] <= data_i;
         end
         else
         begin
            data_o <= mem_r[addr_i];
         end
      end
   end

endmodule

// File: rtl/fifo_1rw_core.sv
`timescale 1ns/10ps

module fifo_1rw_core
#(
   parameter int width_p,
   parameter int els_p
)
(
   input  logic                     clk_i,
   input  logic                     reset_i,
   input  fifo_pkg::fifo_op_e       op_i,
   input  logic [width_p-1:0]       data_i,
   output fifo_pkg::fifo_status_t   status_o,
   output logic                     read_issued_o,
   output logic                     mem_v_o,
   output logic                     mem_w_o,
   output logic [((els_p > 1) ? $clog2(els_p) : 1)-1:0] mem_addr_o,
   output logic [width_p-1:0]       mem_data_o
);

   localparam int ptr_width_lp = (els_p > 1) ? $clog2(els_p) : 1;

   logic [ptr_width_lp-1:0] rd_ptr_r;
   logic [ptr_width_lp-1:0] wr_ptr_r;
   logic                    last_op_read_r;
   logic                    do_enq;
   logic                    do_deq;
   logic                    ptrs_equal;

   // pointers wrap at els_p, which need not be a power of two
   function automatic logic [ptr_width_lp-1:0] next_ptr(input logic [ptr_width_lp-1:0] ptr);
      if (ptr == ptr_width_lp'(els_p - 1))
      begin
         return '0;
      end
      return ptr + ptr_width_lp'(1);
   endfunction

   assign do_enq = (op_i == fifo_pkg::op_enq);
   assign do_deq = (op_i == fifo_pkg::op_deq);

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         rd_ptr_r       <= '0;
         wr_ptr_r       <= '0;
         last_op_read_r <= 1'b1;
      end
      else
      begin
         if (do_enq)
         begin
            wr_ptr_r <= next_ptr(wr_ptr_r);
         end
         if (do_deq)
         begin
            rd_ptr_r <= next_ptr(rd_ptr_r);
         end
         if (do_enq || do_deq)
         begin
            last_op_read_r <= do_deq;
         end
      end
   end

   // equal pointers mean empty after a read and full after a write
   assign ptrs_equal      = (rd_ptr_r == wr_ptr_r);
   assign status_o.empty  = ptrs_equal & last_op_read_r;
   assign status_o.full   = ptrs_equal & ~last_op_read_r;

   assign mem_v_o       = do_enq | do_deq;
   assign mem_w_o       = do_enq;
   assign mem_addr_o    = do_enq ? wr_ptr_r : rd_ptr_r;
   assign mem_data_o    = data_i;
   assign read_issued_o = do_deq;

endmodule

// File: rtl/ram_port_arbiter.sv
`timescale 1ns/10ps

module ram_port_arbiter
(
   input  logic                   clk_i,
   input  logic                   reset_i,
   input  logic                   enq_v_i,
   input  logic                   buf_space_i,
   input  fifo_pkg::fifo_status_t status_i,
   output fifo_pkg::fifo_op_e     op_o,
   output logic                   enq_ready_o
);

   logic enq_req;
   logic deq_req;
   logic grant_enq;
   logic grant_deq;
   // set when the most recent grant went to the dequeue side
   logic last_deq_r;

   assign enq_req = enq_v_i & ~status_i.full;
   assign deq_req = ~status_i.empty & buf_space_i;

   // on a conflict the side that lost last time wins
   assign grant_enq = enq_req & (~deq_req | last_deq_r);
   assign grant_deq = deq_req & (~enq_req | ~last_deq_r);

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         last_deq_r <= 1'b1;
      end
      else if (grant_enq)
      begin
         last_deq_r <= 1'b0;
      end
      else if (grant_deq)
      begin
         last_deq_r <= 1'b1;
      end
   end

   always_comb
   begin
      op_o = fifo_pkg::op_idle;
      if (grant_enq)
      begin
         op_o = fifo_pkg::op_enq;
      end
      else if (grant_deq)
      begin
         op_o = fifo_pkg::op_deq;
      end
   end

   assign enq_ready_o = (op_o == fifo_pkg::op_enq);

endmodule

// File: rtl/deq_buffer.sv
`timescale 1ns/10ps

module deq_buffer
#(
   parameter int width_p
)
(
   input  logic               clk_i,
   input  logic               reset_i,
   input  logic               read_issued_i,
   input  logic [width_p-1:0] mem_data_i,
   output logic               space_o,
   output logic               deq_v_o,
   output logic [width_p-1:0] deq_data_o,
   input  logic               deq_ready_i
);

   logic [width_p-1:0] slot_r [2];
   logic               wr_ptr_r;
   logic               rd_ptr_r;
   logic [1:0]         count_r;
   // a read was issued last cycle, so RAM data is valid now
   logic               inflight_r;
   logic               capture;
   logic               pop;
   logic [1:0]         occupancy;

   assign capture = inflight_r;
   assign pop     = deq_v_o & deq_ready_i;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         inflight_r <= 1'b0;
         wr_ptr_r   <= 1'b0;
         rd_ptr_r   <= 1'b0;
         count_r    <= 2'd0;
      end
      else
      begin
         inflight_r <= read_issued_i;
         if (capture)
         begin
            wr_ptr_r <= ~wr_ptr_r;
         end
         if (pop)
         begin
            rd_ptr_r <= ~rd_ptr_r;
         end
         if (capture && !pop)
         begin
            count_r <= count_r + 2'd1;
         end
         else if (!capture && pop)
         begin
            count_r <= count_r - 2'd1;
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (capture)
      begin
         slot_r[wr_ptr_r] <= mem_data_i;
      end
   end

   // only registered state here, a same-cycle pop does not free a slot
   assign occupancy = count_r + 2'(inflight_r);
   assign space_o   = (occupancy < 2'd2);

   assign deq_v_o    = (count_r != 2'd0);
   assign deq_data_o = slot_r[rd_ptr_r];

endmodule

// File: rtl/fifo_1r1w_large.sv
`timescale 1ns/10ps

module fifo_1r1w_large
#(
   parameter int width_p = fifo_pkg::default_width,
   parameter int els_p   = fifo_pkg::default_els
)
(
   input  logic               clk_i,
   input  logic               reset_i,
   input  logic               enq_v_i,
   input  logic [width_p-1:0] enq_data_i,
   output logic               enq_ready_o,
   output logic               deq_v_o,
   output logic [width_p-1:0] deq_data_o,
   input  logic               deq_ready_i
);

   localparam int ptr_width_lp = (els_p > 1) ? $clog2(els_p) : 1;

   fifo_pkg::fifo_status_t  status;
   fifo_pkg::fifo_op_e      op;
   logic                    buf_space;
   logic                    read_issued;
   logic                    mem_v;
   logic                    mem_w;
   logic [ptr_width_lp-1:0] mem_addr;
   logic [width_p-1:0]      mem_wdata;
   logic [width_p-1:0]      mem_rdata;

   ram_port_arbiter arb
   (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .enq_v_i     (enq_v_i),
      .buf_space_i (buf_space),
      .status_i    (status),
      .op_o        (op),
      .enq_ready_o (enq_ready_o)
   );

   fifo_1rw_core #(.width_p(width_p), .els_p(els_p)) core
   (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .op_i          (op),
      .data_i        (enq_data_i),
      .status_o      (status),
      .read_issued_o (read_issued),
      .mem_v_o       (mem_v),
      .mem_w_o       (mem_w),
      .mem_addr_o    (mem_addr),
      .mem_data_o    (mem_wdata)
   );

   mem_1rw_sync #(.width_p(width_p), .els_p(els_p)) mem
   (
      .clk_i  (clk_i),
      .v_i    (mem_v),
      .w_i    (mem_w),
      .addr_i (mem_addr),
      .data_i (mem_wdata),
      .data_o (mem_rdata)
   );

   deq_buffer #(.width_p(width_p)) dbuf
   (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .read_issued_i (read_issued),
      .mem_data_i    (mem_rdata),
      .space_o       (buf_space),
      .deq_v_o       (deq_v_o),
      .deq_data_o    (deq_data_o),
      .deq_ready_i   (deq_ready_i)
   );

endmodule

// File: bench/tb_fifo_1r1w_large.sv
`timescale 1ns/10ps

module tb_fifo_1r1w_large;

   localparam int width_lp  = fifo_pkg::default_width;
   localparam int els_lp    = fifo_pkg::default_els;
   // total capacity, RAM plus the two-entry dequeue buffer
   localparam int cap_lp    = els_lp + 2;

   localparam int random_cycles_lp  = 2000;
   localparam int fill_cycles_lp    = 3 * cap_lp;
   localparam int drain_cycles_lp   = 3 * cap_lp;
   localparam int both_cycles_lp    = 400;
   // two open-ended drains, each allowed about 4 * cap_lp cycles
   localparam int stim_cycles_lp    = 8 + random_cycles_lp + fill_cycles_lp + drain_cycles_lp
                                    + both_cycles_lp + 8 * cap_lp;
   localparam int timeout_cycles_lp = 4 * stim_cycles_lp;

   logic                clk_i;
   logic                reset_i;
   logic                enq_v_i;
   logic [width_lp-1:0] enq_data_i;
   logic                enq_ready_o;
   logic                deq_v_o;
   logic [width_lp-1:0] deq_data_o;
   logic                deq_ready_i;

   logic [width_lp-1:0] model[$];
   int                  errors = 0;
   int                  checks = 0;
   int                  cycle_count = 0;
   int                  enq_total = 0;
   int                  deq_total = 0;
   int                  enq_gap = 0;
   int                  deq_gap = 0;
   int                  fill_start = 0;
   int                  phase_start = 0;
   logic                fill_check = 1'b0;
   logic                gap_check = 1'b0;

   fifo_1r1w_large #(.width_p(width_lp), .els_p(els_lp)) UUT
   (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .enq_v_i     (enq_v_i),
      .enq_data_i  (enq_data_i),
      .enq_ready_o (enq_ready_o),
      .deq_v_o     (deq_v_o),
      .deq_data_o  (deq_data_o),
      .deq_ready_i (deq_ready_i)
   );

   initial
   begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   always @(posedge clk_i)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= timeout_cycles_lp)
      begin
         $display("timeout: run did not finish within %0d cycles", timeout_cycles_lp);
         $display("Simulation FAILED");
         $finish;
      end
   end

   task automatic compare_data(input string name, input logic [width_lp-1:0] got,
                               input logic [width_lp-1:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("[FAIL] %s: got 0x%h, expected 0x%h (cycle %0d)", name, got, exp, cycle_count);
      end
   endtask

   task automatic compare_flag(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("[FAIL] %s: got 0x%h, expected 0x%h (cycle %0d)", name, got, exp, cycle_count);
      end
   endtask

   task automatic compare_count(input string name, input int got, input int exp);
      checks++;
      if (got != exp)
      begin
         errors++;
         $display("[FAIL] %s: got 0x%0h, expected 0x%0h (cycle %0d)", name, got, exp, cycle_count);
      end
   endtask

   task automatic report(input string msg);
      errors++;
      $display("error at cycle %0d: %s", cycle_count, msg);
   endtask

   // sampled mid-cycle, inputs and outputs are settled for the coming edge
   task automatic observe();
      logic [width_lp-1:0] expected;
      if (enq_total == 0)
      begin
         compare_flag("deq_v_o", deq_v_o, 1'b0);
      end
      if (deq_v_o && (model.size() == 0))
      begin
         report("deq_v_o is high with no word outstanding");
      end
      if (deq_v_o && deq_ready_i && (model.size() != 0))
      begin
         expected = model.pop_front();
         compare_data("deq_data_o", deq_data_o, expected);
         deq_total++;
         deq_gap = 0;
      end
      else
      begin
         deq_gap++;
      end
      if (fill_check && ((enq_total - fill_start) >= cap_lp))
      begin
         compare_flag("enq_ready_o", enq_ready_o, 1'b0);
      end
      if (enq_v_i && enq_ready_o)
      begin
         model.push_back(enq_data_i);
         enq_total++;
         enq_gap = 0;
      end
      else
      begin
         enq_gap++;
      end
      if (gap_check && ((enq_gap >= 2 * cap_lp) || (deq_gap >= 2 * cap_lp)))
      begin
         report("a channel went too long without a transfer");
         enq_gap = 0;
         deq_gap = 0;
      end
   endtask

   task automatic next_cycle();
      @(negedge clk_i);
      observe();
      @(posedge clk_i);
      #1;
   endtask

   task automatic drain_all();
      enq_v_i     = 1'b0;
      deq_ready_i = 1'b1;
      while ((model.size() != 0) || deq_v_o)
      begin
         next_cycle();
      end
   endtask

   initial
   begin
      void'($urandom(17));
      reset_i     = 1'b1;
      enq_v_i     = 1'b0;
      enq_data_i  = '0;
      deq_ready_i = 1'b0;
      repeat (8) @(posedge clk_i);
      #1;
      reset_i = 1'b0;

      // a few idle cycles, deq_v_o must stay low
      repeat (3) next_cycle();

      repeat (random_cycles_lp)
      begin
         enq_v_i     = (($urandom % 2) == 1);
         deq_ready_i = (($urandom % 2) == 1);
         enq_data_i  = $urandom;
         next_cycle();
      end
      drain_all();

      // fill with the output stalled
      deq_ready_i = 1'b0;
      enq_v_i     = 1'b1;
      fill_start  = enq_total;
      fill_check  = 1'b1;
      repeat (fill_cycles_lp)
      begin
         enq_data_i = $urandom;
         next_cycle();
      end
      fill_check = 1'b0;
      compare_count("enqueues accepted while stalled", enq_total - fill_start, cap_lp);

      enq_v_i     = 1'b0;
      deq_ready_i = 1'b1;
      phase_start = deq_total;
      repeat (drain_cycles_lp) next_cycle();
      compare_count("dequeues after fill", deq_total - phase_start, cap_lp);
      compare_count("model depth after drain", model.size(), 0);
      compare_flag("deq_v_o", deq_v_o, 1'b0);

      // both sides busy, the arbiter has to alternate
      enq_v_i     = 1'b1;
      deq_ready_i = 1'b1;
      enq_gap     = 0;
      deq_gap     = 0;
      gap_check   = 1'b1;
      repeat (both_cycles_lp)
      begin
         enq_data_i = $urandom;
         next_cycle();
      end
      gap_check = 1'b0;
      drain_all();

      $display("checks %0d, errors %0d, enqueued %0d, dequeued %0d",
               checks, errors, enq_total, deq_total);
      if (errors == 0)
      begin
         $display("Simulation PASSED");
      end
      else
      begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

// File: compile.f
rtl/fifo_pkg.sv
rtl/mem_1rw_sync.sv
rtl/fifo_1rw_core.sv
rtl/ram_port_arbiter.sv
rtl/deq_buffer.sv
rtl/fifo_1r1w_large.sv
bench/tb_fifo_1r1w_large.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and the log"

obj_dir/sim: compile.f rtl/*.sv bench/*.sv
	verilator --binary --timing -f compile.f --top-module tb_fifo_1r1w_large -o sim

test: obj_dir/sim
	./obj_dir/sim > $(LOG); status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then exit 1; fi
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "failure found in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
